// File: hw/rv_pkg.sv
// rv32i core shared types and constants
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t DEFAULT_RESET_PC = 32'h8000_0000;

    // major opcodes that the core executes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, seen through each encoding
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [2:0] {
        OP_ALU_REG, OP_ALU_IMM, OP_LUI, OP_AUIPC, OP_BRANCH, OP_JAL, OP_JALR, OP_NOP
    } op_class_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef struct packed {
        op_class_t  op_class;
        alu_op_t    alu_op;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        word_t inst;
    } fetch_resp_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    next_pc;
        reg_idx_t rd;
        logic     we;
        word_t    wdata;
    } retire_t;

endpackage

`default_nettype wire

// File: hw/alu.sv
// 32-bit integer alu
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::word_t   a,
    input  wire rv_pkg::word_t   b,
    input  wire rv_pkg::alu_op_t op,
    output rv_pkg::word_t        result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// 32 x 32 register file, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire rv_pkg::reg_idx_t rs1,
    input  wire rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t         rdata1,
    output rv_pkg::word_t         rdata2,
    input  wire logic             we,
    input  wire rv_pkg::reg_idx_t rd,
    input  wire rv_pkg::word_t    wdata
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // x0 storage must survive every retire write, including rd == 0
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        we |=> regs[0] == '0);

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
// rv32i instruction decoder
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire rv_pkg::inst_u inst,
    output rv_pkg::decoded_t   dec
);
    import rv_pkg::*;

    always_comb begin
        dec.funct3 = inst.r.funct3;
        dec.rs1    = inst.r.rs1;
        dec.rs2    = inst.r.rs2;
        dec.rd     = inst.r.rd;

        case (inst.r.opcode)
            OPC_OP:     dec.op_class = OP_ALU_REG;
            OPC_OP_IMM: dec.op_class = OP_ALU_IMM;
            OPC_LUI:    dec.op_class = OP_LUI;
            OPC_AUIPC:  dec.op_class = OP_AUIPC;
            OPC_BRANCH: dec.op_class = OP_BRANCH;
            OPC_JAL:    dec.op_class = OP_JAL;
            OPC_JALR:   dec.op_class = OP_JALR;
            default:    dec.op_class = OP_NOP; // loads, stores, system
        endcase

        // no destination for these
        if (dec.op_class == OP_BRANCH || dec.op_class == OP_NOP) dec.rd = '0;

        case (dec.op_class)
            OP_ALU_IMM, OP_JALR: dec.imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            OP_LUI, OP_AUIPC:    dec.imm = {inst.u.imm31_12, 12'b0};
            OP_BRANCH: begin
                dec.imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                           inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            end
            OP_JAL: begin
                dec.imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                           inst.j.imm11, inst.j.imm10_1, 1'b0};
            end
            default: dec.imm = '0;
        endcase

        dec.alu_op = ALU_ADD; // address and link arithmetic
        if (dec.op_class == OP_ALU_REG || dec.op_class == OP_ALU_IMM) begin
            case (inst.r.funct3)
                3'b000: begin
                    if (dec.op_class == OP_ALU_REG && inst.r.funct7[5]) dec.alu_op = ALU_SUB;
                end
                3'b001:  dec.alu_op = ALU_SLL;
                3'b010:  dec.alu_op = ALU_SLT;
                3'b011:  dec.alu_op = ALU_SLTU;
                3'b100:  dec.alu_op = ALU_XOR;
                3'b101:  dec.alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL; // bit 30 in both
                3'b110:  dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
// operand select, branch resolve and write-back value
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire rv_pkg::decoded_t dec,
    input  wire rv_pkg::word_t    rdata1,
    input  wire rv_pkg::word_t    rdata2,
    input  wire rv_pkg::word_t    pc,
    output rv_pkg::word_t         next_pc,
    output logic                  we,
    output rv_pkg::word_t         wdata
);
    import rv_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t pc_plus4;
    logic  take;

    alu alu_inst (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.funct3)
            3'b000:  take = (rdata1 == rdata2);                  // beq
            3'b001:  take = (rdata1 != rdata2);                  // bne
            3'b100:  take = ($signed(rdata1) < $signed(rdata2));  // blt
            3'b101:  take = ($signed(rdata1) >= $signed(rdata2)); // bge
            3'b110:  take = (rdata1 < rdata2);
            3'b111:  take = (rdata1 >= rdata2);
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        alu_a   = rdata1;
        alu_b   = dec.imm;
        next_pc = pc_plus4;
        we      = 1'b0;
        wdata   = alu_result;
        case (dec.op_class)
            OP_ALU_REG: begin
                alu_b = rdata2;
                we    = 1'b1;
            end
            OP_ALU_IMM: we = 1'b1;
            OP_LUI: begin
                alu_a = '0;
                we    = 1'b1;
            end
            OP_AUIPC: begin
                alu_a = pc;
                we    = 1'b1;
            end
            OP_BRANCH: begin
                alu_a = pc; // alu forms the target
                if (take) next_pc = alu_result;
            end
            OP_JAL: begin
                alu_a   = pc;
                next_pc = alu_result;
                we      = 1'b1;
                wdata   = pc_plus4;
            end
            OP_JALR: begin
                next_pc = {alu_result[31:1], 1'b0};
                we      = 1'b1;
                wdata   = pc_plus4;
            end
            default: ; // unsupported, falls through to pc + 4
        endcase
    end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
// pc, fetch handshake and instruction sequencing
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::DEFAULT_RESET_PC
) (
    input  wire logic                clk,
    input  wire logic                reset,
    output rv_pkg::fetch_req_t       fetch_req,
    input  wire logic                fetch_req_ready,
    input  wire rv_pkg::fetch_resp_t fetch_resp,
    output rv_pkg::inst_u            inst,
    output rv_pkg::word_t            pc,
    input  wire rv_pkg::word_t       next_pc,
    input  wire logic                we,
    input  wire rv_pkg::word_t       wdata,
    input  wire rv_pkg::reg_idx_t    rd,
    output rv_pkg::retire_t          retire,
    input  wire logic                retire_ready,
    output logic                     commit
);
    import rv_pkg::*;

    typedef enum logic [1:0] {FETCH, WAIT, RETIRE} state_t;

    state_t state;
    state_t state_next;

    assign commit = retire.valid && retire_ready;

    always_comb begin
        state_next = state;
        case (state)
            FETCH:   if (fetch_req.valid && fetch_req_ready) state_next = WAIT;
            WAIT:    if (fetch_resp.valid) state_next = RETIRE;
            RETIRE:  if (commit) state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (commit) pc <= next_pc;
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == WAIT && fetch_resp.valid) inst <= fetch_resp.inst;
    end

    assign fetch_req.valid = (state == FETCH) && !reset; // low while reset is held
    assign fetch_req.addr  = pc;

    assign retire.valid   = (state == RETIRE);
    assign retire.pc      = pc;
    assign retire.next_pc = next_pc;
    assign retire.rd      = rd;
    assign retire.we      = we;
    assign retire.wdata   = wdata;

    // request may not change or drop while memory is not ready
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        fetch_req.valid && !fetch_req_ready |=> $stable(fetch_req));

    a_resp_in_wait: assert property (@(posedge clk) disable iff (reset)
        fetch_resp.valid |-> state == WAIT);

endmodule

`default_nettype wire

// File: hw/rv_core.sv
// rv32i core top level
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::DEFAULT_RESET_PC
) (
    input  wire logic                clk,
    input  wire logic                reset,
    output rv_pkg::fetch_req_t       fetch_req,
    input  wire logic                fetch_req_ready,
    input  wire rv_pkg::fetch_resp_t fetch_resp,
    output rv_pkg::retire_t          retire,
    input  wire logic                retire_ready
);
    import rv_pkg::*;

    inst_u    inst;
    decoded_t dec;
    word_t    pc;
    word_t    next_pc;
    word_t    rdata1;
    word_t    rdata2;
    word_t    wdata;
    logic     we;
    logic     commit;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_resp      (fetch_resp),
        .inst            (inst),
        .pc              (pc),
        .next_pc         (next_pc),
        .we              (we),
        .wdata           (wdata),
        .rd              (dec.rd),
        .retire          (retire),
        .retire_ready    (retire_ready),
        .commit          (commit)
    );

    decode_unit decode_unit_inst (
        .inst (inst),
        .dec  (dec)
    );

    // written only when the retire handshake completes
    reg_file reg_file_inst (
        .clk    (clk),
        .reset  (reset),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (commit && retire.we),
        .rd     (retire.rd),
        .wdata  (retire.wdata)
    );

    exec_unit exec_unit_inst (
        .dec     (dec),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .pc      (pc),
        .next_pc (next_pc),
        .we      (we),
        .wdata   (wdata)
    );

endmodule

`default_nettype wire

// File: tb/tb_rv_core.sv
// directed testbench for the rv32i core
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t       PC0            = DEFAULT_RESET_PC;
    localparam int          TOTAL_INSTS    = 51;
    localparam int          TIMEOUT_CYCLES = 40 * TOTAL_INSTS + 100;
    localparam logic [31:0] SEED           = 32'hf4fe_52b9;
    localparam word_t       MARKER         = 32'h0010_0f93; // addi x31, x0, 1, never retires

    logic        clk;
    logic        reset;
    fetch_req_t  fetch_req;
    logic        fetch_req_ready;
    fetch_resp_t fetch_resp;
    retire_t     retire;
    logic        retire_ready;

    word_t   prog [$];      // program image from PC0 upward
    retire_t exp_q [$];     // expected retirements in order
    word_t   fetch_log [$]; // accepted fetch addresses since reset

    rv_core rv_core_inst (
        .clk             (clk),
        .reset           (reset),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_resp      (fetch_resp),
        .retire          (retire),
        .retire_ready    (retire_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, string what, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_idx(string name, string what, reg_idx_t expected, reg_idx_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %0d, actual %0d", name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %b, actual %b", name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_retire(string name, string what, retire_t expected, retire_t actual);
        check_bit(name, {what, " valid"}, expected.valid, actual.valid);
        check_word(name, {what, " pc"}, expected.pc, actual.pc);
        check_word(name, {what, " next_pc"}, expected.next_pc, actual.next_pc);
        check_bit(name, {what, " we"}, expected.we, actual.we);
        if (expected.we) begin // rd and wdata are don't care without a write
            check_idx(name, {what, " rd"}, expected.rd, actual.rd);
            check_word(name, {what, " wdata"}, expected.wdata, actual.wdata);
        end
    endtask

    // rv32i encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t mem_word(word_t addr);
        int idx;
        idx = int'((addr - PC0) >> 2);
        if (addr >= PC0 && idx < prog.size()) return prog[idx];
        return {addr[31:7] ^ addr[24:0], 7'b0001011}; // custom-0, retires as nop
    endfunction

    task automatic expect_ret(int pc_off, int next_off, reg_idx_t rd, logic we, word_t wdata);
        retire_t e;
        e.valid   = 1'b1;
        e.pc      = PC0 + word_t'(pc_off);
        e.next_pc = PC0 + word_t'(next_off);
        e.rd      = rd;
        e.we      = we;
        e.wdata   = wdata;
        exp_q.push_back(e);
    endtask

    // memory model, ready drivers and port monitor
    initial begin : environment
        int      delay;
        logic    busy;
        logic    resp_seen;
        logic    held_valid;
        word_t   addr;
        retire_t held;
        void'($urandom(SEED));
        delay           = 0;
        busy            = 1'b0;
        resp_seen       = 1'b0;
        held_valid      = 1'b0;
        addr            = '0;
        held            = '0;
        fetch_req_ready = 1'b0;
        fetch_resp      = '0;
        retire_ready    = 1'b0;
        forever begin
            @(posedge clk);
            if (reset) begin
                busy       = 1'b0;
                resp_seen  = 1'b0;
                held_valid = 1'b0;
            end else begin
                if (!resp_seen) begin
                    check_bit("startup", "retire valid before first response", 1'b0,
                              retire.valid);
                end
                if (fetch_resp.valid) resp_seen = 1'b1;
                if (held_valid) compare_retire("back-pressure", "held retire", held, retire);
                held_valid = retire.valid && !retire_ready;
                held       = retire;
                if (fetch_req.valid && fetch_req_ready) begin
                    busy  = 1'b1;
                    addr  = fetch_req.addr;
                    delay = $urandom_range(0, 3); // idle cycles before the answer
                    fetch_log.push_back(addr);
                end
            end
            #1;
            fetch_resp = '0;
            if (busy && delay == 0) begin
                fetch_resp.valid = 1'b1;
                fetch_resp.inst  = mem_word(addr);
                busy             = 1'b0;
            end else if (busy) begin
                delay--;
            end
            fetch_req_ready = !busy && ($urandom_range(0, 3) != 0);
            retire_ready    = ($urandom_range(0, 2) != 0);
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
                abort_run();
            end
        end
    end

    task automatic reset_core(string name);
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (2) @(posedge clk);
        check_bit(name, "retire valid in reset", 1'b0, retire.valid);
        check_bit(name, "fetch valid in reset", 1'b0, fetch_req.valid);
        fetch_log.delete();
        #1 reset = 1'b0;
    endtask

    task automatic run_program(string name);
        int k;
        reset_core(name);
        k = 0;
        while (k < exp_q.size()) begin
            @(posedge clk);
            if (retire.valid && retire_ready) begin
                compare_retire(name, $sformatf("retire %0d", k), exp_q[k], retire);
                k++;
            end
        end
        // fetch order must follow the retired pc chain
        for (int i = 0; i < exp_q.size(); i++) begin
            check_word(name, $sformatf("fetch %0d addr", i), exp_q[i].pc, fetch_log[i]);
        end
        prog.delete();
        exp_q.delete();
    endtask

    task automatic test_reset_fetch();
        prog.push_back(enc_i(12'h005, 5'd0, 3'b000, 5'd1, OPC_OP_IMM)); // addi x1, x0, 5
        prog.push_back(enc_i(12'hfff, 5'd1, 3'b000, 5'd2, OPC_OP_IMM)); // addi x2, x1, -1
        expect_ret(0, 4, 5'd1, 1'b1, 32'd5);
        expect_ret(4, 8, 5'd2, 1'b1, 32'd4);
        run_program("reset_fetch");
    endtask

    task automatic test_alu_ops();
        prog.push_back(enc_i(12'hff9, 5'd0, 3'b000, 5'd1, OPC_OP_IMM)); // x1 = -7
        prog.push_back(enc_i(12'h003, 5'd0, 3'b000, 5'd2, OPC_OP_IMM)); // x2 = 3
        prog.push_back(enc_r(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3));    // sub
        prog.push_back(enc_r(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd4));    // slt
        prog.push_back(enc_r(7'b0000000, 5'd2, 5'd1, 3'b011, 5'd5));    // sltu
        prog.push_back(enc_r(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd6));    // sra
        prog.push_back(enc_r(7'b0000000, 5'd2, 5'd1, 3'b101, 5'd7));    // srl
        prog.push_back(enc_i(12'h000, 5'd1, 3'b010, 5'd8, OPC_OP_IMM)); // slti
        prog.push_back(enc_i(12'h401, 5'd1, 3'b101, 5'd9, OPC_OP_IMM)); // srai by 1
        prog.push_back(enc_i(12'h0ff, 5'd2, 3'b100, 5'd10, OPC_OP_IMM)); // xori
        prog.push_back(enc_r(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd11));   // or
        prog.push_back(enc_r(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd12));   // and
        prog.push_back(enc_r(7'b0000000, 5'd2, 5'd2, 3'b001, 5'd13));   // sll
        expect_ret(0, 4, 5'd1, 1'b1, 32'hffff_fff9);
        expect_ret(4, 8, 5'd2, 1'b1, 32'd3);
        expect_ret(8, 12, 5'd3, 1'b1, 32'd10);
        expect_ret(12, 16, 5'd4, 1'b1, 32'd1);   // -7 < 3 signed
        expect_ret(16, 20, 5'd5, 1'b1, 32'd0);   // but not unsigned
        expect_ret(20, 24, 5'd6, 1'b1, 32'hffff_ffff);
        expect_ret(24, 28, 5'd7, 1'b1, 32'h1fff_ffff);
        expect_ret(28, 32, 5'd8, 1'b1, 32'd1);
        expect_ret(32, 36, 5'd9, 1'b1, 32'hffff_fffc);
        expect_ret(36, 40, 5'd10, 1'b1, 32'h0000_00fc);
        expect_ret(40, 44, 5'd11, 1'b1, 32'hffff_fffb);
        expect_ret(44, 48, 5'd12, 1'b1, 32'd1);
        expect_ret(48, 52, 5'd13, 1'b1, 32'h0000_0018);
        run_program("alu_ops");
    endtask

    task automatic test_x0();
        prog.push_back(enc_i(12'h009, 5'd0, 3'b000, 5'd0, OPC_OP_IMM)); // addi x0, x0, 9
        prog.push_back(enc_i(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        prog.push_back(enc_r(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd2));    // add x2, x0, x1
        prog.push_back(enc_r(7'b0000000, 5'd0, 5'd1, 3'b000, 5'd3));    // add x3, x1, x0
        expect_ret(0, 4, 5'd0, 1'b1, 32'd9);
        expect_ret(4, 8, 5'd1, 1'b1, 32'h123);
        expect_ret(8, 12, 5'd2, 1'b1, 32'h123);
        expect_ret(12, 16, 5'd3, 1'b1, 32'h123);
        run_program("x0");
    endtask

    task automatic test_upper_imm();
        prog.push_back(enc_u(20'h12345, 5'd1, OPC_LUI));
        prog.push_back(enc_u(20'h00001, 5'd2, OPC_AUIPC));
        prog.push_back(enc_u(20'hfffff, 5'd3, OPC_AUIPC));
        prog.push_back(enc_u(20'hfffff, 5'd4, OPC_LUI));
        expect_ret(0, 4, 5'd1, 1'b1, 32'h1234_5000);
        expect_ret(4, 8, 5'd2, 1'b1, 32'h8000_1004);
        expect_ret(8, 12, 5'd3, 1'b1, 32'h7fff_f008);
        expect_ret(12, 16, 5'd4, 1'b1, 32'hffff_f000);
        run_program("upper_imm");
    endtask

    // x1 = -2, x2 = 3, each branch taken then not taken
    task automatic test_branches();
        prog.push_back(enc_i(12'hffe, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        prog.push_back(enc_i(12'h003, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        prog.push_back(enc_b(13'd8, 5'd1, 5'd1, 3'b000)); // beq  8
        prog.push_back(MARKER);
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000)); // beq  16
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b001)); // bne  20
        prog.push_back(MARKER);
        prog.push_back(enc_b(13'd8, 5'd1, 5'd1, 3'b001)); // bne  28
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b100)); // blt  32
        prog.push_back(MARKER);
        prog.push_back(enc_b(13'd8, 5'd1, 5'd2, 3'b100)); // blt  40
        prog.push_back(enc_b(13'd8, 5'd1, 5'd2, 3'b101)); // bge  44
        prog.push_back(MARKER);
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b101)); // bge  52
        prog.push_back(enc_b(13'd8, 5'd1, 5'd2, 3'b110)); // bltu 56
        prog.push_back(MARKER);
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b110)); // bltu 64
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b111)); // bgeu 68
        prog.push_back(MARKER);
        prog.push_back(enc_b(13'd8, 5'd1, 5'd2, 3'b111)); // bgeu 76
        prog.push_back(enc_b(13'd8, 5'd0, 5'd0, 3'b000)); // 80
        prog.push_back(enc_i(12'h007, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
        prog.push_back(enc_b(13'h1ffc, 5'd0, 5'd5, 3'b000)); // beq x5, x0, -4
        expect_ret(0, 4, 5'd1, 1'b1, 32'hffff_fffe);
        expect_ret(4, 8, 5'd2, 1'b1, 32'd3);
        expect_ret(8, 16, 5'd0, 1'b0, 0);
        expect_ret(16, 20, 5'd0, 1'b0, 0);
        expect_ret(20, 28, 5'd0, 1'b0, 0);
        expect_ret(28, 32, 5'd0, 1'b0, 0);
        expect_ret(32, 40, 5'd0, 1'b0, 0);
        expect_ret(40, 44, 5'd0, 1'b0, 0);
        expect_ret(44, 52, 5'd0, 1'b0, 0);
        expect_ret(52, 56, 5'd0, 1'b0, 0);
        expect_ret(56, 64, 5'd0, 1'b0, 0);
        expect_ret(64, 68, 5'd0, 1'b0, 0);
        expect_ret(68, 76, 5'd0, 1'b0, 0);
        expect_ret(76, 80, 5'd0, 1'b0, 0);
        expect_ret(80, 88, 5'd0, 1'b0, 0);
        expect_ret(88, 84, 5'd0, 1'b0, 0);   // backward while x5 is zero
        expect_ret(84, 88, 5'd5, 1'b1, 32'd7);
        expect_ret(88, 92, 5'd0, 1'b0, 0);
        run_program("branches");
    endtask

    task automatic test_jumps_and_nop();
        prog.push_back(enc_u(20'h00000, 5'd1, OPC_AUIPC));            // x1 = PC0
        prog.push_back(enc_j(21'd12, 5'd2));
        prog.push_back(MARKER);
        prog.push_back(MARKER);
        prog.push_back(enc_i(12'h01d, 5'd1, 3'b000, 5'd3, OPC_JALR)); // odd target
        prog.push_back(MARKER);
        prog.push_back(MARKER);
        prog.push_back(enc_i(12'h000, 5'd0, 3'b010, 5'd4, 7'b0000011)); // lw, unsupported
        prog.push_back(enc_r(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd5));
        prog.push_back(enc_j(21'd12, 5'd0));
        prog.push_back(enc_i(12'h055, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
        prog.push_back(enc_j(21'd12, 5'd0));
        prog.push_back(enc_j(21'h1ffff8, 5'd8));                      // jal x8, -8
        prog.push_back(MARKER);
        prog.push_back(enc_i(12'h000, 5'd8, 3'b000, 5'd9, OPC_OP_IMM));
        expect_ret(0, 4, 5'd1, 1'b1, 32'h8000_0000);
        expect_ret(4, 16, 5'd2, 1'b1, 32'h8000_0008);
        expect_ret(16, 28, 5'd3, 1'b1, 32'h8000_0014);
        expect_ret(28, 32, 5'd0, 1'b0, 0);
        expect_ret(32, 36, 5'd5, 1'b1, 32'h0000_001c); // sum of both links wraps
        expect_ret(36, 48, 5'd0, 1'b1, 32'h8000_0028);
        expect_ret(48, 40, 5'd8, 1'b1, 32'h8000_0034);
        expect_ret(40, 44, 5'd7, 1'b1, 32'h0000_0055);
        expect_ret(44, 56, 5'd0, 1'b1, 32'h8000_0030);
        expect_ret(56, 60, 5'd9, 1'b1, 32'h8000_0034);
        run_program("jumps_and_nop");
    endtask

    initial begin
        reset = 1'b1;
        test_reset_fetch();
        test_alu_ops();
        test_x0();
        test_upper_imm();
        test_branches();
        test_jumps_and_nop();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/rv_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/exec_unit.sv
hw/fetch_unit.sv
hw/rv_core.sv
tb/tb_rv_core.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rv_core
FILELIST = all.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP) with $(SIM)"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
